// ==== bench/mem_patterns.txt ====
# test port op addr len data strb resp; addr, data and strb in hex, the rest decimal
# port 0 fetch, 1 load/store; op 0 read, 1 write, 2 read issued together with the next line
1 1 1 00000000 0 0123456789abcdef ff 0
1 1 1 00000008 0 fedcba9876543210 ff 0
1 1 1 000007f8 0 a5a5a5a55a5a5a5a ff 0
1 1 0 00000000 0 0000000000000000 00 0
1 1 0 000007f8 0 0000000000000000 00 0
2 1 1 00000008 0 1122334455667788 0f 0
2 1 0 00000008 0 0000000000000000 00 0
3 0 0 00000000 1 0000000000000000 00 0
4 0 2 00000000 1 0000000000000000 00 0
4 1 0 000007f8 0 0000000000000000 00 0
5 1 1 00000800 0 deadbeefdeadbeef ff 2
5 1 0 00000800 0 0000000000000000 00 2
5 0 0 00001000 0 0000000000000000 00 2
5 1 0 00000000 0 0000000000000000 00 0
6 1 1 00000010 0 0f1e2d3c4b5a6978 ff 0
6 1 1 00000018 0 8796a5b4c3d2e1f0 ff 0
6 0 0 00000010 1 0000000000000000 00 0
6 1 1 00000010 0 ffffffffffffffff 3c 0
6 1 0 00000010 0 0000000000000000 00 0
6 1 0 00000018 0 0000000000000000 00 0

// ==== sources.f ====
hw/bus_pkg.sv
hw/arb_pkg.sv
hw/axi_mem_if.sv
hw/axi_read_arbiter.sv
hw/axi_sram.sv
hw/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// ==== Makefile ====
TOP = tb_mem_subsys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f sources.f -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int MEM_WORDS = 256;
    localparam int IDX_W     = $clog2(MEM_WORDS);
    localparam int BP_TEST   = 6;

    typedef struct {
        int             test;
        int             port;
        int             op;
        bus_pkg::addr_t addr;
        int             len;
        bus_pkg::data_t data;
        bus_pkg::strb_t strb;
        bus_pkg::resp_t resp;
    } pattern_t;

    logic           clk;
    logic           rst;
    logic           if_ar_valid_i, if_ar_ready_o, if_r_ready_i, if_r_valid_o, if_r_last_o;
    bus_pkg::addr_t if_ar_addr_i, ls_aw_addr_i, ls_ar_addr_i;
    bus_pkg::len_t  if_ar_len_i;
    bus_pkg::data_t if_r_data_o, ls_w_data_i, ls_r_data_o;
    bus_pkg::resp_t if_r_resp_o, ls_b_resp_o, ls_r_resp_o;
    bus_pkg::strb_t ls_w_strb_i;
    logic           ls_aw_valid_i, ls_aw_ready_o, ls_w_valid_i, ls_w_ready_o;
    logic           ls_b_ready_i, ls_b_valid_o, ls_ar_valid_i, ls_ar_ready_o;
    logic           ls_r_ready_i, ls_r_valid_o;

    // Expected SRAM contents
    bus_pkg::data_t model [MEM_WORDS];
    pattern_t       pats [$];

    int  errors;
    int  checks;
    int  test_errors;
    bit  loaded;
    bit  bp_on;
    time fetch_last_t;
    time ls_first_t;

    mem_subsys_top #(.MEM_WORDS(MEM_WORDS)) i_dut (.*);

    always #5 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic expect_equal(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (act !== exp) begin
            $display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            count_error();
        end
    endtask

    // Ready stays high unless the current test asks for back-pressure
    function automatic logic pick_ready();
        if (!bp_on) begin
            return 1'b1;
        end
        return ($urandom % 3) != 0;
    endfunction

    function automatic bus_pkg::data_t predict(bus_pkg::addr_t addr, int beat);
        bus_pkg::addr_t idx;
        idx = (addr >> 3) + beat;
        if (idx >= MEM_WORDS) begin
            return '0;
        end
        return model[idx[IDX_W-1:0]];
    endfunction

    task automatic model_write(bus_pkg::addr_t addr, bus_pkg::data_t data, bus_pkg::strb_t strb);
        bus_pkg::addr_t idx;
        idx = addr >> 3;
        if (idx < MEM_WORDS) begin
            for (int i = 0; i < 8; i++) begin
                if (strb[i]) begin
                    model[idx[IDX_W-1:0]][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
    endtask

    task automatic lsu_write(bus_pkg::addr_t addr, bus_pkg::data_t data, bus_pkg::strb_t strb,
                             bus_pkg::resp_t resp);
        logic hs;
        ls_aw_valid_i = 1'b1;
        ls_aw_addr_i  = addr;
        ls_w_valid_i  = 1'b1;
        ls_w_data_i   = data;
        ls_w_strb_i   = strb;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs = ls_aw_ready_o && ls_w_ready_o;
            next_cycle();
        end
        ls_aw_valid_i = 1'b0;
        ls_w_valid_i  = 1'b0;
        model_write(addr, data, strb);
        hs = 1'b0;
        while (!hs) begin
            ls_b_ready_i = pick_ready();
            @(negedge clk);
            hs = ls_b_valid_o && ls_b_ready_i;
            if (hs) begin
                expect_equal("ls_b_resp_o", 64'(resp), 64'(ls_b_resp_o));
            end
            next_cycle();
        end
        ls_b_ready_i = 1'b0;
    endtask

    task automatic do_read(int port, bus_pkg::addr_t addr, int len, bus_pkg::resp_t resp);
        int             beats;
        int             last;
        logic           hs;
        logic           rdy;
        logic           vld;
        bus_pkg::data_t data;
        bus_pkg::resp_t rsp;
        string          pfx;
        pfx  = (port == 0) ? "if" : "ls";
        last = (port == 0) ? len : 0;
        if (port == 0) begin
            if_ar_valid_i = 1'b1;
            if_ar_addr_i  = addr;
            if_ar_len_i   = len[0];
        end else begin
            ls_ar_valid_i = 1'b1;
            ls_ar_addr_i  = addr;
        end
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs = (port == 0) ? if_ar_ready_o : ls_ar_ready_o;
            next_cycle();
        end
        if (port == 0) begin
            if_ar_valid_i = 1'b0;
        end else begin
            ls_ar_valid_i = 1'b0;
        end
        beats = 0;
        while (beats <= last) begin
            rdy = pick_ready();
            if (port == 0) begin
                if_r_ready_i = rdy;
            end else begin
                ls_r_ready_i = rdy;
            end
            @(negedge clk);
            vld  = (port == 0) ? if_r_valid_o : ls_r_valid_o;
            data = (port == 0) ? if_r_data_o : ls_r_data_o;
            rsp  = (port == 0) ? if_r_resp_o : ls_r_resp_o;
            if (port == 1 && vld && ls_first_t == '0) begin
                ls_first_t = $time;
            end
            if (vld && rdy) begin
                expect_equal({pfx, "_r_data_o"}, predict(addr, beats), data);
                expect_equal({pfx, "_r_resp_o"}, 64'(resp), 64'(rsp));
                if (port == 0) begin
                    expect_equal("if_r_last_o", 64'(beats == last), 64'(if_r_last_o));
                    fetch_last_t = $time;
                end
                beats++;
            end
            next_cycle();
        end
        if (port == 0) begin
            if_r_ready_i = 1'b0;
        end else begin
            ls_r_ready_i = 1'b0;
        end
        // A repeated beat would still be waiting here
        @(negedge clk);
        vld = (port == 0) ? if_r_valid_o : ls_r_valid_o;
        checks++;
        if (vld) begin
            $display("Extra R beat on the %s port at %0d ns", pfx, $time);
            count_error();
        end
        next_cycle();
    endtask

    initial begin
        int       fd;
        int       n;
        int       idx;
        int       tests;
        string    line;
        pattern_t p;
        pattern_t q;
        void'($urandom(32'h5afb_4bbe));
        clk           = 1'b0;
        rst           = 1'b1;
        if_ar_valid_i = 1'b0;
        if_ar_addr_i  = '0;
        if_ar_len_i   = '0;
        if_r_ready_i  = 1'b0;
        ls_aw_valid_i = 1'b0;
        ls_aw_addr_i  = '0;
        ls_w_valid_i  = 1'b0;
        ls_w_data_i   = '0;
        ls_w_strb_i   = '0;
        ls_b_ready_i  = 1'b0;
        ls_ar_valid_i = 1'b0;
        ls_ar_addr_i  = '0;
        ls_r_ready_i  = 1'b0;
        fd = $fopen("bench/mem_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file bench/mem_patterns.txt");
            errors++;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 0 && line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%d %d %d %h %d %h %h %d", p.test, p.port, p.op, p.addr,
                            p.len, p.data, p.strb, p.resp);
                if (n == 8) begin
                    pats.push_back(p);
                end else if (n > 0) begin
                    $display("Malformed pattern line: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
            if (pats.size() == 0) begin
                $display("The pattern file holds no transactions");
                errors++;
            end
        end
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst   = 1'b0;
        idx   = 0;
        tests = 0;
        while (idx < pats.size()) begin
            p     = pats[idx];
            bp_on = (p.test == BP_TEST);
            if (p.op == 1) begin
                lsu_write(p.addr, p.data, p.strb, p.resp);
            end else if (p.op == 2 && idx + 1 < pats.size()) begin
                // Both ARs go up in the same cycle and fetch must be served first
                q            = pats[idx + 1];
                fetch_last_t = '0;
                ls_first_t   = '0;
                fork
                    do_read(p.port, p.addr, p.len, p.resp);
                    do_read(q.port, q.addr, q.len, q.resp);
                join
                checks++;
                if (ls_first_t <= fetch_last_t) begin
                    $display("Load/store R valid rose at %0d ns, before the fetch read ended",
                             ls_first_t);
                    count_error();
                end
                idx++;
            end else begin
                do_read(p.port, p.addr, p.len, p.resp);
            end
            idx++;
            if (idx >= pats.size() || pats[idx].test != p.test) begin
                $display("Test %0d: %s, %0d errors", p.test, (test_errors == 0) ? "ok" : "FAILED",
                         test_errors);
                tests++;
                test_errors = 0;
            end
        end
        $display("Finished %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Allows 200 ns per pattern line plus reset
    initial begin
        wait (loaded);
        #(pats.size() * 200 + 8 * 10);
        $display("Watchdog expired at %0d ns before all patterns finished", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           rst,

    // Fetch port
    input  logic           if_ar_valid_i,
    input  bus_pkg::addr_t if_ar_addr_i,
    input  bus_pkg::len_t  if_ar_len_i,
    output logic           if_ar_ready_o,
    input  logic           if_r_ready_i,
    output logic           if_r_valid_o,
    output bus_pkg::data_t if_r_data_o,
    output bus_pkg::resp_t if_r_resp_o,
    output logic           if_r_last_o,

    // Load/store port
    input  logic           ls_aw_valid_i,
    input  bus_pkg::addr_t ls_aw_addr_i,
    output logic           ls_aw_ready_o,
    input  logic           ls_w_valid_i,
    input  bus_pkg::data_t ls_w_data_i,
    input  bus_pkg::strb_t ls_w_strb_i,
    output logic           ls_w_ready_o,
    input  logic           ls_b_ready_i,
    output logic           ls_b_valid_o,
    output bus_pkg::resp_t ls_b_resp_o,
    input  logic           ls_ar_valid_i,
    input  bus_pkg::addr_t ls_ar_addr_i,
    output logic           ls_ar_ready_o,
    input  logic           ls_r_ready_i,
    output logic           ls_r_valid_o,
    output bus_pkg::data_t ls_r_data_o,
    output bus_pkg::resp_t ls_r_resp_o
);

    axi_mem_if mem_bus ();

    axi_read_arbiter i_arb (
        .clk           (clk),
        .rst           (rst),
        .if_ar_valid_i (if_ar_valid_i),
        .if_ar_addr_i  (if_ar_addr_i),
        .if_ar_len_i   (if_ar_len_i),
        .if_ar_ready_o (if_ar_ready_o),
        .if_r_ready_i  (if_r_ready_i),
        .if_r_valid_o  (if_r_valid_o),
        .if_r_data_o   (if_r_data_o),
        .if_r_resp_o   (if_r_resp_o),
        .if_r_last_o   (if_r_last_o),
        .ls_aw_valid_i (ls_aw_valid_i),
        .ls_aw_addr_i  (ls_aw_addr_i),
        .ls_aw_ready_o (ls_aw_ready_o),
        .ls_w_valid_i  (ls_w_valid_i),
        .ls_w_data_i   (ls_w_data_i),
        .ls_w_strb_i   (ls_w_strb_i),
        .ls_w_ready_o  (ls_w_ready_o),
        .ls_b_ready_i  (ls_b_ready_i),
        .ls_b_valid_o  (ls_b_valid_o),
        .ls_b_resp_o   (ls_b_resp_o),
        .ls_ar_valid_i (ls_ar_valid_i),
        .ls_ar_addr_i  (ls_ar_addr_i),
        .ls_ar_ready_o (ls_ar_ready_o),
        .ls_r_ready_i  (ls_r_ready_i),
        .ls_r_valid_o  (ls_r_valid_o),
        .ls_r_data_o   (ls_r_data_o),
        .ls_r_resp_o   (ls_r_resp_o),
        .mem           (mem_bus.master)
    );

    axi_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) i_sram (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus.slave)
    );

endmodule

// ==== hw/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram #(
    parameter int MEM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst,
    axi_mem_if.slave bus
);

    localparam int             IDX_W   = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam bus_pkg::addr_t WORDS_A = MEM_WORDS;

    bus_pkg::data_t mem_q [MEM_WORDS];

    // Read engine
    bus_pkg::addr_t ar_idx;
    bus_pkg::addr_t rd_idx_q;
    bus_pkg::addr_t rd_next;
    bus_pkg::len_t  rd_left_q;
    logic           r_valid_q;
    bus_pkg::data_t r_data_q;
    bus_pkg::resp_t r_resp_q;
    logic           ar_xfer;
    logic           r_xfer;
    logic           rd_load;
    logic           rd_ok;

    // Write engine
    bus_pkg::addr_t aw_idx;
    logic           wr_accept;
    logic           wr_ok;
    logic           b_valid_q;
    bus_pkg::resp_t b_resp_q;

    assign ar_idx  = bus.ar_addr >> 3;
    assign ar_xfer = bus.ar_valid && bus.ar_ready;
    assign r_xfer  = bus.r_valid && bus.r_ready;

    // Load a beat on AR accept, or for the second half of a burst
    assign rd_load = ar_xfer || (r_xfer && (rd_left_q != '0));
    assign rd_next = ar_xfer ? ar_idx : rd_idx_q;
    assign rd_ok   = (rd_next < WORDS_A);

    assign bus.ar_ready = !r_valid_q;
    assign bus.r_valid  = r_valid_q;
    assign bus.r_data   = r_data_q;
    assign bus.r_resp   = r_resp_q;
    assign bus.r_last   = (rd_left_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid_q <= 1'b0;
            rd_left_q <= '0;
        end else if (ar_xfer) begin
            r_valid_q <= 1'b1;
            rd_left_q <= bus.ar_len;
        end else if (r_xfer) begin
            if (rd_left_q != '0) begin
                rd_left_q <= '0;
            end else begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_load) begin
            rd_idx_q <= rd_next + 32'd1;
            r_data_q <= rd_ok ? mem_q[rd_next[IDX_W-1:0]] : '0;
            r_resp_q <= rd_ok ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
        end
    end

    // AW and W are taken together
    assign aw_idx    = bus.aw_addr >> 3;
    assign wr_ok     = (aw_idx < WORDS_A);
    assign wr_accept = bus.aw_valid && bus.w_valid && !b_valid_q;

    assign bus.aw_ready = wr_accept;
    assign bus.w_ready  = wr_accept;
    assign bus.b_valid  = b_valid_q;
    assign bus.b_resp   = b_resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid_q <= 1'b0;
        end else if (wr_accept) begin
            b_valid_q <= 1'b1;
        end else if (bus.b_ready) begin
            b_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            b_resp_q <= wr_ok ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
        end
    end

    // Out of range writes are dropped
    always_ff @(posedge clk) begin
        if (wr_accept && wr_ok) begin
            for (int i = 0; i < 8; i++) begin
                if (bus.w_strb[i]) begin
                    mem_q[aw_idx[IDX_W-1:0]][8*i +: 8] <= bus.w_data[8*i +: 8];
                end
            end
        end
    end

    a_r_stable: assert property (@(posedge clk) disable iff (rst)
        (bus.r_valid && !bus.r_ready) |=> (bus.r_valid && $stable(bus.r_data) &&
                                           $stable(bus.r_resp) && $stable(bus.r_last)))
        else $error("R beat changed before ready");

    // A write response needs AW and W to have transferred on the same edge
    a_b_after_accept: assert property (@(posedge clk) disable iff (rst)
        $rose(bus.b_valid) |-> $past(bus.aw_valid && bus.aw_ready &&
                                     bus.w_valid && bus.w_ready))
        else $error("B valid without an AW and W transfer");

endmodule

// ==== hw/axi_read_arbiter.sv ====
`timescale 1ns/1ps

module axi_read_arbiter (
    input  logic           clk,
    input  logic           rst,

    // Fetch port reads only
    input  logic           if_ar_valid_i,
    input  bus_pkg::addr_t if_ar_addr_i,
    input  bus_pkg::len_t  if_ar_len_i,
    output logic           if_ar_ready_o,
    input  logic           if_r_ready_i,
    output logic           if_r_valid_o,
    output bus_pkg::data_t if_r_data_o,
    output bus_pkg::resp_t if_r_resp_o,
    output logic           if_r_last_o,

    // Load/store port
    input  logic           ls_aw_valid_i,
    input  bus_pkg::addr_t ls_aw_addr_i,
    output logic           ls_aw_ready_o,
    input  logic           ls_w_valid_i,
    input  bus_pkg::data_t ls_w_data_i,
    input  bus_pkg::strb_t ls_w_strb_i,
    output logic           ls_w_ready_o,
    input  logic           ls_b_ready_i,
    output logic           ls_b_valid_o,
    output bus_pkg::resp_t ls_b_resp_o,
    input  logic           ls_ar_valid_i,
    input  bus_pkg::addr_t ls_ar_addr_i,
    output logic           ls_ar_ready_o,
    input  logic           ls_r_ready_i,
    output logic           ls_r_valid_o,
    output bus_pkg::data_t ls_r_data_o,
    output bus_pkg::resp_t ls_r_resp_o,

    axi_mem_if.master      mem
);

    arb_pkg::rd_state_e state_q;
    arb_pkg::rd_state_e state_d;
    arb_pkg::owner_e    owner_q;
    arb_pkg::owner_e    owner_d;
    logic               rd_out_q;
    logic               granted;
    logic               fetch_sel;
    logic               ls_sel;
    logic               ar_xfer;
    logic               r_last_xfer;

    // Only the load/store port writes
    assign mem.aw_valid  = ls_aw_valid_i;
    assign mem.aw_addr   = ls_aw_addr_i;
    assign ls_aw_ready_o = mem.aw_ready;
    assign mem.w_valid   = ls_w_valid_i;
    assign mem.w_data    = ls_w_data_i;
    assign mem.w_strb    = ls_w_strb_i;
    assign ls_w_ready_o  = mem.w_ready;
    assign mem.b_ready   = ls_b_ready_i;
    assign ls_b_valid_o  = mem.b_valid;
    assign ls_b_resp_o   = mem.b_resp;

    assign granted   = (state_q != arb_pkg::RD_IDLE);
    assign fetch_sel = granted && (owner_q == arb_pkg::OWN_FETCH);
    assign ls_sel    = granted && (owner_q == arb_pkg::OWN_LSU);

    // AR goes out once per grant
    assign mem.ar_valid = !rd_out_q && ((fetch_sel && if_ar_valid_i) ||
                                        (ls_sel && ls_ar_valid_i));
    assign mem.ar_addr  = fetch_sel ? if_ar_addr_i : ls_ar_addr_i;
    assign mem.ar_len   = fetch_sel ? if_ar_len_i : '0;
    assign if_ar_ready_o = fetch_sel && !rd_out_q && mem.ar_ready;
    assign ls_ar_ready_o = ls_sel && !rd_out_q && mem.ar_ready;

    assign mem.r_ready  = (fetch_sel && if_r_ready_i) || (ls_sel && ls_r_ready_i);
    assign if_r_valid_o = fetch_sel && mem.r_valid;
    assign if_r_data_o  = mem.r_data;
    assign if_r_resp_o  = mem.r_resp;
    assign if_r_last_o  = mem.r_last;
    assign ls_r_valid_o = ls_sel && mem.r_valid;
    assign ls_r_data_o  = mem.r_data;
    assign ls_r_resp_o  = mem.r_resp;

    assign ar_xfer     = mem.ar_valid && mem.ar_ready;
    assign r_last_xfer = rd_out_q && mem.r_valid && mem.r_ready && mem.r_last;

    // Fetch wins a tie and a waiting load/store read follows a fetch directly
    always_comb begin
        state_d = state_q;
        owner_d = owner_q;
        case (state_q)
            arb_pkg::RD_IDLE: begin
                if (if_ar_valid_i) begin
                    state_d = arb_pkg::RD_FETCH;
                    owner_d = arb_pkg::OWN_FETCH;
                end else if (ls_ar_valid_i) begin
                    state_d = arb_pkg::RD_LSU;
                    owner_d = arb_pkg::OWN_LSU;
                end
            end
            arb_pkg::RD_FETCH: begin
                if (r_last_xfer) begin
                    if (ls_ar_valid_i) begin
                        state_d = arb_pkg::RD_LSU;
                        owner_d = arb_pkg::OWN_LSU;
                    end else begin
                        state_d = arb_pkg::RD_IDLE;
                    end
                end
            end
            arb_pkg::RD_LSU: begin
                if (r_last_xfer) begin
                    state_d = arb_pkg::RD_IDLE;
                end
            end
            default: begin
                state_d = arb_pkg::RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= arb_pkg::RD_IDLE;
            owner_q  <= arb_pkg::OWN_FETCH;
            rd_out_q <= 1'b0;
        end else begin
            state_q <= state_d;
            owner_q <= owner_d;
            if (ar_xfer) begin
                rd_out_q <= 1'b1;
            end else if (r_last_xfer) begin
                rd_out_q <= 1'b0;
            end
        end
    end

    // Every beat from the SRAM belongs to the granted read, so only the owner sees it
    a_r_to_owner: assert property (@(posedge clk) disable iff (rst)
        mem.r_valid |-> (granted && rd_out_q))
        else $error("R beat with no read in flight");

    a_owner_stable: assert property (@(posedge clk) disable iff (rst)
        (rd_out_q && !r_last_xfer) |=> $stable(owner_q))
        else $error("owner changed during a read");

endmodule

// ==== hw/axi_mem_if.sv ====
`timescale 1ns/1ps

interface axi_mem_if;

    // Write address
    logic           aw_valid;
    logic           aw_ready;
    bus_pkg::addr_t aw_addr;

    // Write data
    logic           w_valid;
    logic           w_ready;
    bus_pkg::data_t w_data;
    bus_pkg::strb_t w_strb;

    // Write response
    logic           b_valid;
    logic           b_ready;
    bus_pkg::resp_t b_resp;

    // Read address
    logic           ar_valid;
    logic           ar_ready;
    bus_pkg::addr_t ar_addr;
    bus_pkg::len_t  ar_len;

    // Read data
    logic           r_valid;
    logic           r_ready;
    bus_pkg::data_t r_data;
    bus_pkg::resp_t r_resp;
    logic           r_last;

    modport master (
        output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        output ar_valid, ar_addr, ar_len, r_ready,
        input  aw_ready, w_ready, b_valid, b_resp,
        input  ar_ready, r_valid, r_data, r_resp, r_last
    );

    modport slave (
        input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        input  ar_valid, ar_addr, ar_len, r_ready,
        output aw_ready, w_ready, b_valid, b_resp,
        output ar_ready, r_valid, r_data, r_resp, r_last
    );

endinterface

// ==== hw/arb_pkg.sv ====
package arb_pkg;

    // Who holds the read channels right now
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_LSU
    } rd_state_e;

    typedef enum logic {
        OWN_FETCH,
        OWN_LSU
    } owner_e;

endpackage

// ==== hw/bus_pkg.sv ====
package bus_pkg;

    // Byte address
    typedef logic [31:0] addr_t;

    // One data beat
    typedef logic [63:0] data_t;

    // One enable bit per data byte
    typedef logic [7:0] strb_t;

    typedef logic [1:0] resp_t;

    // Beats minus one, so 0 is a single beat and 1 a two-beat burst
    typedef logic [0:0] len_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

endpackage
